// File: filelist.f
+incdir+.
soc_pkg.sv
bus_decoder.sv
sys_ctrl.sv
gpio_port.sv
pwm_timer.sv
periph_subsys.sv
tb_periph.sv

// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_periph -f filelist.f
	./obj_dir/Vtb_periph | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: periph_input.hex
// command address data expected, one record per line
// data FFFFFFFF on a write is a random word, mask 0 on a read compares to it
00000002 00000004 FFFFFFFF FFFFFFFF
00000006 00000001 00000010 00000000
00000006 00000002 00000008 00000000
// Register readback and output ports
00000001 00001004 FFFFFFFF 00000000
00000002 00001004 00000000 00000000
00000007 00000000 00000000 00000000
00000001 00001008 FFFFFFFF 00000000
00000002 00001008 00000000 00000000
00000007 00000001 00000000 00000000
00000001 00000004 FFFFFFFF 00000000
00000002 00000004 00000000 00000000
00000001 00003004 FFFFFFFF 00000000
00000002 00003004 00000000 00000000
00000001 00002004 00000036 00000000
00000002 00002004 FFFFFFFF 00000016
00000007 00000002 FFFFFFFF 00000016
00000001 00002008 00000005 00000000
00000002 00002008 FFFFFFFF 00000005
00000007 00000003 FFFFFFFF 00000005
// Machine timer and software interrupts
00000001 00000004 00000000 00000000
00000006 00000001 00000010 00000001
00000002 0000000C 00000008 00000008
00000001 00000004 FFFFFFF0 00000000
00000006 00000001 00000010 00000000
00000001 00000008 00000002 00000000
00000006 00000002 00000008 00000002
00000002 00000008 FFFFFFFF 00000002
00000001 00000008 00000001 00000000
00000006 00000002 00000008 00000001
// Unmapped slave selects
00000003 00004000 00000000 00000000
00000003 0000F00C 00000000 00000000
00000002 00000008 FFFFFFFF 00000001
00000003 00008010 00000000 00000000
// GPIO inputs and edge interrupts
00000004 00000001 A5A5F00F 00000000
00000005 00001000 FFFFFFFF A5A5F00F
00000002 00001010 FFFFFFFF 00000000
00000001 0000200C 00000015 00000000
00000004 00000002 0000000F 00000000
00000005 00002000 0000001F 0000000F
00000002 00002010 FFFFFFFF 00000005
00000002 0000000C 00000002 00000002
00000001 00002010 0000001F 00000000
00000002 00002010 FFFFFFFF 00000000
00000002 0000000C 00000002 00000000
00000004 00000002 0000001F 00000000
00000005 00002000 0000001F 0000001F
00000002 00002010 FFFFFFFF 00000010
00000001 00002010 00000010 00000000
00000002 0000000C 00000007 00000000
// PWM output against duty
00000001 00003008 00000008 00000000
00000001 00003004 00000000 00000000
00000001 0000300C 00000001 00000000
00000006 00000000 00000020 00000000
00000002 00003000 FFFFFFF8 00000000
00000001 00003004 0000000A 00000000
00000006 00000000 00000020 00000001
00000001 0000300C 00000000 00000000
00000006 00000000 00000020 00000000
// PWM wrap interrupt
00000001 0000300C 00000004 00000000
00000002 0000300C 00000007 00000000
00000001 0000300C 00000003 00000000
00000005 0000300C 00000004 00000004
00000002 0000000C 00000004 00000004
00000001 0000300C 00000002 00000000
00000002 0000000C 00000004 00000004
00000001 0000300C 00000006 00000000
00000002 0000300C 00000007 00000002
00000002 0000000C 00000004 00000000
00000000 00000000 00000000 00000000

// File: tb_checks.svh
/*
 * Testbench helpers: compare tasks for bus words, single bits
 * and the ack/err response, plus the Galois LFSR word source
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_word(input string name, input soc_pkg::word_t got,
                          input soc_pkg::word_t exp);
   if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      report_failure();
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      report_failure();
   end
endtask

// Exactly one of ack or err per access
task automatic check_err(input string name, input logic got_err, input logic got_ack,
                         input logic exp_err);
   if (got_err !== exp_err || got_ack !== !exp_err) begin
      $display("ERR %s: o_err %h o_ack %h, expected o_err %h o_ack %h",
               name, got_err, got_ack, exp_err, !exp_err);
      report_failure();
   end
endtask

// **************************************************
// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic soc_pkg::word_t lfsr_step(input soc_pkg::word_t s);
   soc_pkg::word_t n;
   n = {1'b0, s[31:1]};
   if (s[0]) begin
      n = n ^ 32'h80200003;
   end
   return n;
endfunction

// One step per bit taken
function automatic soc_pkg::word_t next_rand_word();
   soc_pkg::word_t w;
   int             i;
   w = '0;
   for (i = 0; i < 32; i++) begin
      w          = {w[30:0], rand_state[0]};
      rand_state = lfsr_step(rand_state);
   end
   return w;
endfunction

`endif

// File: tb_periph.sv
/*
 * Peripheral subsystem testbench with clock and reset, record reader,
 * host bus access, command loop and run timeout
 */
`timescale 1ns/100ps
`default_nettype none

module tb_periph;

   localparam int LED_W    = 32;
   localparam int BTN_W    = 5;
   localparam int MAX_REC  = 128;
   localparam int MAX_POLL = 64;

   // Record commands
   localparam logic [31:0] CMD_END    = 32'h0;
   localparam logic [31:0] CMD_WRITE  = 32'h1;
   localparam logic [31:0] CMD_READ   = 32'h2;
   localparam logic [31:0] CMD_RDERR  = 32'h3;
   localparam logic [31:0] CMD_PINS   = 32'h4;
   localparam logic [31:0] CMD_POLL   = 32'h5;
   localparam logic [31:0] CMD_SAMPLE = 32'h6;
   localparam logic [31:0] CMD_PORT   = 32'h7;

   localparam soc_pkg::word_t RAND_MARK = 32'hFFFFFFFF;

   logic               clk;
   logic               rst;
   logic               cyc;
   logic               stb;
   logic               we;
   soc_pkg::bus_addr_u adr;
   soc_pkg::word_t     dat;
   logic               ack;
   logic               err;
   soc_pkg::word_t     rdt;
   logic [LED_W-1:0]   led_pins;
   logic [BTN_W-1:0]   btn_pins;
   logic [LED_W-1:0]   led;
   logic [LED_W-1:0]   led_oe;
   logic [BTN_W-1:0]   btn;
   logic [BTN_W-1:0]   btn_oe;
   logic               pwm;
   logic               timer_irq;
   logic [1:0]         sw_irq;

   logic [31:0]        stim [0:4*MAX_REC-1];
   int                 n_rec;
   int                 limit = 0;
   int                 cycles = 0;
   soc_pkg::word_t     rand_state;
   soc_pkg::word_t     last_rand;

   `include "tb_checks.svh"

   periph_subsys #(
      .LED_WIDTH (LED_W),
      .BTN_WIDTH (BTN_W)
   ) i_periph_subsys (
      .clk         (clk),
      .i_rst       (rst),
      .i_cyc       (cyc),
      .i_stb       (stb),
      .i_we        (we),
      .i_adr       (adr),
      .i_dat       (dat),
      .o_ack       (ack),
      .o_err       (err),
      .o_rdt       (rdt),
      .i_led_pins  (led_pins),
      .i_btn_pins  (btn_pins),
      .o_led       (led),
      .o_led_oe    (led_oe),
      .o_btn       (btn),
      .o_btn_oe    (btn_oe),
      .o_pwm       (pwm),
      .o_timer_irq (timer_irq),
      .o_sw_irq    (sw_irq)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         report_failure();
      end
   end

   task automatic report_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // **************************************************
   // Single host access driven on the falling edge
   task automatic bus_access(input logic wr, input logic [15:0] a,
                             input soc_pkg::word_t wdata, output soc_pkg::word_t rdata,
                             output logic got_ack, output logic got_err);
      @(negedge clk);
      cyc     = 1'b1;
      stb     = 1'b1;
      we      = wr;
      adr.raw = a;
      dat     = wdata;
      @(negedge clk);
      while (!ack && !err) begin
         @(negedge clk);
      end
      rdata   = rdt;
      got_ack = ack;
      got_err = err;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
   endtask

   task automatic run_record(input int n);
      logic [31:0]    cmd;
      logic [31:0]    a;
      logic [31:0]    d;
      logic [31:0]    e;
      soc_pkg::word_t wd;
      soc_pkg::word_t rd;
      soc_pkg::word_t got;
      logic           got_ack;
      logic           got_err;
      logic           done;
      int             polls;
      int             i;
      string          nm;
      cmd = stim[4*n];
      a   = stim[4*n+1];
      d   = stim[4*n+2];
      e   = stim[4*n+3];
      nm  = $sformatf("o_rdt[%h]", a[15:0]);
      case (cmd)
         CMD_WRITE: begin
            wd = d;
            if (d == RAND_MARK) begin
               wd        = next_rand_word();
               last_rand = wd;
            end
            bus_access(1'b1, a[15:0], wd, rd, got_ack, got_err);
            check_err(nm, got_err, got_ack, 1'b0);
         end
         CMD_READ: begin
            bus_access(1'b0, a[15:0], '0, rd, got_ack, got_err);
            check_err(nm, got_err, got_ack, 1'b0);
            // Zero mask means the last random word written
            if (d == '0) begin
               check_word(nm, rd, last_rand);
            end else begin
               check_word(nm, rd & d, e);
            end
         end
         CMD_RDERR: begin
            bus_access(1'b0, a[15:0], '0, rd, got_ack, got_err);
            check_err(nm, got_err, got_ack, 1'b1);
         end
         CMD_PINS: begin
            @(negedge clk);
            if (a == 32'h1) begin
               led_pins = d;
            end else if (a == 32'h2) begin
               btn_pins = d[BTN_W-1:0];
            end else begin
               $display("Record %0d names an unknown pin group %h", n, a);
               report_failure();
            end
         end
         CMD_POLL: begin
            done  = 1'b0;
            polls = 0;
            while (!done && polls < MAX_POLL) begin
               bus_access(1'b0, a[15:0], '0, rd, got_ack, got_err);
               check_err(nm, got_err, got_ack, 1'b0);
               polls = polls + 1;
               done  = ((rd & d) == e);
            end
            if (!done) begin
               $display("Polling %h never saw %h under mask %h in %0d reads",
                        a[15:0], e, d, MAX_POLL);
               report_failure();
            end
         end
         CMD_SAMPLE: begin
            for (i = 0; i < int'(d); i++) begin
               @(negedge clk);
               case (a)
                  32'h0:   check_bit("o_pwm", pwm, e[0]);
                  32'h1:   check_bit("o_timer_irq", timer_irq, e[0]);
                  default: check_word("o_sw_irq", soc_pkg::word_t'(sw_irq), e);
               endcase
            end
         end
         CMD_PORT: begin
            @(negedge clk);
            case (a)
               32'h0: begin
                  got = soc_pkg::word_t'(led);
                  nm  = "o_led";
               end
               32'h1: begin
                  got = soc_pkg::word_t'(led_oe);
                  nm  = "o_led_oe";
               end
               32'h2: begin
                  got = soc_pkg::word_t'(btn);
                  nm  = "o_btn";
               end
               default: begin
                  got = soc_pkg::word_t'(btn_oe);
                  nm  = "o_btn_oe";
               end
            endcase
            if (d == '0) begin
               check_word(nm, got, last_rand);
            end else begin
               check_word(nm, got & d, e);
            end
         end
         default: begin
            $display("Record %0d holds an unknown command %h", n, cmd);
            report_failure();
         end
      endcase
   endtask

   // **************************************************
   // Main sequence
   initial begin
      int idx;
      rst        = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat        = '0;
      led_pins   = '0;
      btn_pins   = '0;
      rand_state = 32'h19de95f9;
      last_rand  = '0;
      $readmemh("periph_input.hex", stim);
      n_rec = 0;
      while (n_rec < MAX_REC && stim[4*n_rec] != CMD_END) begin
         n_rec = n_rec + 1;
      end
      if (n_rec == MAX_REC) begin
         $display("The stimulus file has no end record");
         report_failure();
      end
      limit = n_rec * 100;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      for (idx = 0; idx < n_rec; idx++) begin
         run_record(idx);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: periph_subsys.sv
/*
 * Peripheral subsystem top: address decoder, system controller,
 * LED/switch GPIO, push-button GPIO and PWM timer
 */
`timescale 1ns/100ps
`default_nettype none

module periph_subsys #(
   parameter int LED_WIDTH = 32,
   parameter int BTN_WIDTH = 5
) (
   input  wire                   clk,
   input  wire                   i_rst,
   // Host bus
   input  wire                   i_cyc,
   input  wire                   i_stb,
   input  wire                   i_we,
   input  wire soc_pkg::bus_addr_u i_adr,
   input  wire soc_pkg::word_t    i_dat,
   output logic                  o_ack,
   output logic                  o_err,
   output soc_pkg::word_t        o_rdt,
   // Pins
   input  wire [LED_WIDTH-1:0]   i_led_pins,
   input  wire [BTN_WIDTH-1:0]   i_btn_pins,
   output logic [LED_WIDTH-1:0]  o_led,
   output logic [LED_WIDTH-1:0]  o_led_oe,
   output logic [BTN_WIDTH-1:0]  o_btn,
   output logic [BTN_WIDTH-1:0]  o_btn_oe,
   output logic                  o_pwm,
   output logic                  o_timer_irq,
   output logic [1:0]            o_sw_irq
);

   logic              sys_stb;
   logic              led_stb;
   logic              btn_stb;
   logic              pwm_stb;
   logic              bus_we;
   soc_pkg::reg_idx_t bus_reg;
   soc_pkg::word_t    bus_wdat;
   logic              sys_ack;
   logic              led_ack;
   logic              btn_ack;
   logic              pwm_ack;
   soc_pkg::word_t    sys_rdt;
   soc_pkg::word_t    led_rdt;
   soc_pkg::word_t    btn_rdt;
   soc_pkg::word_t    pwm_rdt;
   logic              led_irq;
   logic              btn_irq;
   logic              pwm_irq;

   bus_decoder u_bus_decoder (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_cyc     (i_cyc),
      .i_stb     (i_stb),
      .i_we      (i_we),
      .i_adr     (i_adr),
      .i_dat     (i_dat),
      .o_ack     (o_ack),
      .o_err     (o_err),
      .o_rdt     (o_rdt),
      .o_sys_stb (sys_stb),
      .o_led_stb (led_stb),
      .o_btn_stb (btn_stb),
      .o_pwm_stb (pwm_stb),
      .o_we      (bus_we),
      .o_reg     (bus_reg),
      .o_wdat    (bus_wdat),
      .i_sys_ack (sys_ack),
      .i_led_ack (led_ack),
      .i_btn_ack (btn_ack),
      .i_pwm_ack (pwm_ack),
      .i_sys_rdt (sys_rdt),
      .i_led_rdt (led_rdt),
      .i_btn_rdt (btn_rdt),
      .i_pwm_rdt (pwm_rdt)
   );

   sys_ctrl u_sys_ctrl (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_stb       (sys_stb),
      .i_we        (bus_we),
      .i_reg       (bus_reg),
      .i_wdat      (bus_wdat),
      .i_led_irq   (led_irq),
      .i_btn_irq   (btn_irq),
      .i_pwm_irq   (pwm_irq),
      .o_ack       (sys_ack),
      .o_rdt       (sys_rdt),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq    (o_sw_irq)
   );

   // LEDs and switches
   gpio_port #(.WIDTH(LED_WIDTH)) u_gpio_led (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_stb     (led_stb),
      .i_we      (bus_we),
      .i_reg     (bus_reg),
      .i_wdat    (bus_wdat),
      .i_pins    (i_led_pins),
      .o_ack     (led_ack),
      .o_rdt     (led_rdt),
      .o_gpio    (o_led),
      .o_gpio_oe (o_led_oe),
      .o_irq     (led_irq)
   );

   // Push buttons
   gpio_port #(.WIDTH(BTN_WIDTH)) u_gpio_btn (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_stb     (btn_stb),
      .i_we      (bus_we),
      .i_reg     (bus_reg),
      .i_wdat    (bus_wdat),
      .i_pins    (i_btn_pins),
      .o_ack     (btn_ack),
      .o_rdt     (btn_rdt),
      .o_gpio    (o_btn),
      .o_gpio_oe (o_btn_oe),
      .o_irq     (btn_irq)
   );

   pwm_timer u_pwm_timer (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_stb  (pwm_stb),
      .i_we   (bus_we),
      .i_reg  (bus_reg),
      .i_wdat (bus_wdat),
      .o_ack  (pwm_ack),
      .o_rdt  (pwm_rdt),
      .o_pwm  (o_pwm),
      .o_irq  (pwm_irq)
   );

endmodule

`default_nettype wire

// File: pwm_timer.sv
/*
 * PWM timer: period and duty registers, free-running
 * counter and a wrap interrupt with write-1 clear
 */
`timescale 1ns/100ps
`default_nettype none

module pwm_timer (
   input  wire                   clk,
   input  wire                   i_rst,
   input  wire                   i_stb,
   input  wire                   i_we,
   input  wire soc_pkg::reg_idx_t i_reg,
   input  wire soc_pkg::word_t    i_wdat,
   output logic                  o_ack,
   output soc_pkg::word_t        o_rdt,
   output logic                  o_pwm,
   output logic                  o_irq
);

   soc_pkg::word_t cnt;
   soc_pkg::word_t duty;
   soc_pkg::word_t period;
   logic           en;
   logic           ie;
   logic           pend;
   logic           acc;
   logic           wr;
   logic           wr_period;
   logic           wr_ctrl;
   logic           run;
   logic           wrap;

   assign acc       = i_stb & ~o_ack;
   assign wr        = acc & i_we;
   assign wr_period = wr & (i_reg == soc_pkg::PWM_PERIOD);
   assign wr_ctrl   = wr & (i_reg == soc_pkg::PWM_CTRL);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ack <= 1'b0;
      end else begin
         o_ack <= acc;
      end
   end

   // **************************************************
   // Counter
   assign run  = en & (period != '0);
   assign wrap = run & (cnt == period - 1'b1);

   // A new period restarts the count so it never sits above the limit
   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt <= '0;
      end else if (!run || wr_period || wrap) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         duty   <= '0;
         period <= '0;
         en     <= 1'b0;
         ie     <= 1'b0;
         pend   <= 1'b0;
      end else begin
         if (wr && i_reg == soc_pkg::PWM_DUTY) begin
            duty <= i_wdat;
         end
         if (wr_period) begin
            period <= i_wdat;
         end
         if (wr_ctrl) begin
            en <= i_wdat[0];
            ie <= i_wdat[1];
         end
         // Set wins over a simultaneous clear
         pend <= (pend & ~(wr_ctrl & i_wdat[2])) | wrap;
      end
   end

   assign o_pwm = en & (cnt < duty);
   assign o_irq = pend & ie;

   always_ff @(posedge clk) begin
      if (acc && !i_we) begin
         case (i_reg)
            soc_pkg::PWM_CNT:    o_rdt <= cnt;
            soc_pkg::PWM_DUTY:   o_rdt <= duty;
            soc_pkg::PWM_PERIOD: o_rdt <= period;
            soc_pkg::PWM_CTRL:   o_rdt <= soc_pkg::word_t'({pend, ie, en});
            default:             o_rdt <= '0;
         endcase
      end
   end

   a_cnt_in_range : assert property (@(posedge clk) disable iff (i_rst)
      run |-> (cnt < period));

endmodule

`default_nettype wire

// File: gpio_port.sv
/*
 * GPIO block: output data, output enable, two-flop input
 * synchronizer and masked rising-edge interrupt
 */
`timescale 1ns/100ps
`default_nettype none

module gpio_port #(
   parameter int WIDTH = 32
) (
   input  wire                   clk,
   input  wire                   i_rst,
   input  wire                   i_stb,
   input  wire                   i_we,
   input  wire soc_pkg::reg_idx_t i_reg,
   input  wire soc_pkg::word_t    i_wdat,
   input  wire [WIDTH-1:0]       i_pins,
   output logic                  o_ack,
   output soc_pkg::word_t        o_rdt,
   output logic [WIDTH-1:0]      o_gpio,
   output logic [WIDTH-1:0]      o_gpio_oe,
   output logic                  o_irq
);

   logic             acc;
   logic             wr;
   logic [WIDTH-1:0] sync1;
   logic [WIDTH-1:0] sync2;
   logic [WIDTH-1:0] prev;
   logic [WIDTH-1:0] rise;
   logic [WIDTH-1:0] mask;
   logic [WIDTH-1:0] mask_next;
   logic [WIDTH-1:0] pend;
   logic [WIDTH-1:0] pend_next;

   assign acc = i_stb & ~o_ack;
   assign wr  = acc & i_we;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ack <= 1'b0;
      end else begin
         o_ack <= acc;
      end
   end

   // **************************************************
   // Input synchronizer and edge detect
   always_ff @(posedge clk) begin
      if (i_rst) begin
         sync1 <= '0;
         sync2 <= '0;
         prev  <= '0;
      end else begin
         sync1 <= i_pins;
         sync2 <= sync1;
         prev  <= sync2;
      end
   end

   assign rise = sync2 & ~prev;

   // Pending bits only live under the mask, also when the mask shrinks
   always_comb begin
      mask_next = mask;
      if (wr && i_reg == soc_pkg::GPIO_MASK) begin
         mask_next = i_wdat[WIDTH-1:0];
      end
      pend_next = pend;
      if (wr && i_reg == soc_pkg::GPIO_PEND) begin
         pend_next = pend_next & ~i_wdat[WIDTH-1:0];
      end
      pend_next = (pend_next | (rise & mask)) & mask_next;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_gpio    <= '0;
         o_gpio_oe <= '0;
         mask      <= '0;
         pend      <= '0;
      end else begin
         mask <= mask_next;
         pend <= pend_next;
         if (wr && i_reg == soc_pkg::GPIO_OUT) begin
            o_gpio <= i_wdat[WIDTH-1:0];
         end
         if (wr && i_reg == soc_pkg::GPIO_OE) begin
            o_gpio_oe <= i_wdat[WIDTH-1:0];
         end
      end
   end

   assign o_irq = |pend;

   always_ff @(posedge clk) begin
      if (acc && !i_we) begin
         case (i_reg)
            soc_pkg::GPIO_IN:   o_rdt <= soc_pkg::word_t'(sync2);
            soc_pkg::GPIO_OUT:  o_rdt <= soc_pkg::word_t'(o_gpio);
            soc_pkg::GPIO_OE:   o_rdt <= soc_pkg::word_t'(o_gpio_oe);
            soc_pkg::GPIO_MASK: o_rdt <= soc_pkg::word_t'(mask);
            soc_pkg::GPIO_PEND: o_rdt <= soc_pkg::word_t'(pend);
            default:            o_rdt <= '0;
         endcase
      end
   end

   a_pend_masked : assert property (@(posedge clk) disable iff (i_rst)
      (pend & ~mask) == '0);

endmodule

`default_nettype wire

// File: sys_ctrl.sv
/*
 * System controller: machine timer with compare,
 * software interrupt bits and interrupt status
 */
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl (
   input  wire                   clk,
   input  wire                   i_rst,
   input  wire                   i_stb,
   input  wire                   i_we,
   input  wire soc_pkg::reg_idx_t i_reg,
   input  wire soc_pkg::word_t    i_wdat,
   input  wire                   i_led_irq,
   input  wire                   i_btn_irq,
   input  wire                   i_pwm_irq,
   output logic                  o_ack,
   output soc_pkg::word_t        o_rdt,
   output logic                  o_timer_irq,
   output logic [1:0]            o_sw_irq
);

   soc_pkg::word_t mtime;
   soc_pkg::word_t mtimecmp;
   logic           acc;
   logic           wr;
   logic [3:0]     irq_stat;

   assign acc = i_stb & ~o_ack;
   assign wr  = acc & i_we;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ack <= 1'b0;
      end else begin
         o_ack <= acc;
      end
   end

   // **************************************************
   // Machine timer
   always_ff @(posedge clk) begin
      if (i_rst) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         mtimecmp <= '1;
         o_sw_irq <= 2'b00;
      end else if (wr) begin
         case (i_reg)
            soc_pkg::SYS_MTIMECMP: mtimecmp <= i_wdat;
            soc_pkg::SYS_SWIRQ:    o_sw_irq <= i_wdat[1:0];
            default: ;
         endcase
      end
   end

   assign o_timer_irq = (mtime >= mtimecmp);

   always_comb begin
      irq_stat                     = 4'b0000;
      irq_stat[soc_pkg::IRQ_LED]   = i_led_irq;
      irq_stat[soc_pkg::IRQ_BTN]   = i_btn_irq;
      irq_stat[soc_pkg::IRQ_PWM]   = i_pwm_irq;
      irq_stat[soc_pkg::IRQ_TIMER] = o_timer_irq;
   end

   // **************************************************
   // Read back
   always_ff @(posedge clk) begin
      if (acc && !i_we) begin
         case (i_reg)
            soc_pkg::SYS_MTIME:    o_rdt <= mtime;
            soc_pkg::SYS_MTIMECMP: o_rdt <= mtimecmp;
            soc_pkg::SYS_SWIRQ:    o_rdt <= soc_pkg::word_t'(o_sw_irq);
            soc_pkg::SYS_IRQSTAT:  o_rdt <= soc_pkg::word_t'(irq_stat);
            default:               o_rdt <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: bus_decoder.sv
/*
 * Host bus address decoder: slave strobes, ack merge,
 * read data mux and error response for unmapped addresses
 */
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
   input  wire                clk,
   input  wire                i_rst,
   // Host side
   input  wire                i_cyc,
   input  wire                i_stb,
   input  wire                i_we,
   input  wire soc_pkg::bus_addr_u i_adr,
   input  wire soc_pkg::word_t     i_dat,
   output logic               o_ack,
   output logic               o_err,
   output soc_pkg::word_t     o_rdt,
   // Slave side
   output logic               o_sys_stb,
   output logic               o_led_stb,
   output logic               o_btn_stb,
   output logic               o_pwm_stb,
   output logic               o_we,
   output soc_pkg::reg_idx_t  o_reg,
   output soc_pkg::word_t     o_wdat,
   input  wire                i_sys_ack,
   input  wire                i_led_ack,
   input  wire                i_btn_ack,
   input  wire                i_pwm_ack,
   input  wire soc_pkg::word_t     i_sys_rdt,
   input  wire soc_pkg::word_t     i_led_rdt,
   input  wire soc_pkg::word_t     i_btn_rdt,
   input  wire soc_pkg::word_t     i_pwm_rdt
);

   logic                req;
   logic                unmapped;
   soc_pkg::slave_sel_e sel_q;

   assign req = i_cyc & i_stb;

   always_comb begin
      o_sys_stb = 1'b0;
      o_led_stb = 1'b0;
      o_btn_stb = 1'b0;
      o_pwm_stb = 1'b0;
      unmapped  = 1'b0;
      case (i_adr.f.sel)
         soc_pkg::SEL_SYS: o_sys_stb = req;
         soc_pkg::SEL_LED: o_led_stb = req;
         soc_pkg::SEL_BTN: o_btn_stb = req;
         soc_pkg::SEL_PWM: o_pwm_stb = req;
         default:          unmapped  = 1'b1;
      endcase
   end

   assign o_we   = i_we;
   assign o_reg  = i_adr.f.idx;
   assign o_wdat = i_dat;

   // Error answered by the decoder itself, same timing as a slave ack
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_err <= 1'b0;
      end else begin
         o_err <= req & unmapped & ~o_err;
      end
   end

   // Select of the access in flight, steers the read mux in the ack cycle
   always_ff @(posedge clk) begin
      if (req) begin
         sel_q <= i_adr.f.sel;
      end
   end

   assign o_ack = i_sys_ack | i_led_ack | i_btn_ack | i_pwm_ack;

   always_comb begin
      case (sel_q)
         soc_pkg::SEL_SYS: o_rdt = i_sys_rdt;
         soc_pkg::SEL_LED: o_rdt = i_led_rdt;
         soc_pkg::SEL_BTN: o_rdt = i_btn_rdt;
         soc_pkg::SEL_PWM: o_rdt = i_pwm_rdt;
         default:          o_rdt = '0;
      endcase
   end

   a_ack_err_excl : assert property (@(posedge clk) disable iff (i_rst)
      !(o_ack && o_err));

endmodule

`default_nettype wire

// File: soc_pkg.sv
/*
 * Shared definitions for the peripheral subsystem: bus widths, the host
 * address union, slave select codes, register indices and IRQ bit positions
 */
`default_nettype none

package soc_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [3:0]        reg_idx_t;

   // Slave select, upper nibble of the byte address
   typedef enum logic [3:0] {
      SEL_SYS = 4'd0,
      SEL_LED = 4'd1,
      SEL_BTN = 4'd2,
      SEL_PWM = 4'd3
   } slave_sel_e;

   typedef struct packed {
      slave_sel_e sel;
      logic [5:0] gap;
      reg_idx_t   idx;
      logic [1:0] off;
   } bus_addr_f_t;

   typedef union packed {
      logic [ADDR_W-1:0] raw;
      bus_addr_f_t       f;
   } bus_addr_u;

   // **************************************************
   // System controller registers
   localparam reg_idx_t SYS_MTIME    = 4'd0;
   localparam reg_idx_t SYS_MTIMECMP = 4'd1;
   localparam reg_idx_t SYS_SWIRQ    = 4'd2;
   localparam reg_idx_t SYS_IRQSTAT  = 4'd3;

   // GPIO registers
   localparam reg_idx_t GPIO_IN   = 4'd0;
   localparam reg_idx_t GPIO_OUT  = 4'd1;
   localparam reg_idx_t GPIO_OE   = 4'd2;
   localparam reg_idx_t GPIO_MASK = 4'd3;
   localparam reg_idx_t GPIO_PEND = 4'd4;

   // PWM registers
   localparam reg_idx_t PWM_CNT    = 4'd0;
   localparam reg_idx_t PWM_DUTY   = 4'd1;
   localparam reg_idx_t PWM_PERIOD = 4'd2;
   localparam reg_idx_t PWM_CTRL   = 4'd3;

   // **************************************************
   // Bit positions in SYS_IRQSTAT
   localparam int IRQ_LED   = 0;
   localparam int IRQ_BTN   = 1;
   localparam int IRQ_PWM   = 2;
   localparam int IRQ_TIMER = 3;

endpackage

`default_nettype wire
